//--- include/exe_settings.svh
`ifndef EXE_SETTINGS_SVH
`define EXE_SETTINGS_SVH

// datapath widths of the execute stage

`define XLEN       32  // data and address
`define INST_W     32
`define REG_ADDR_W 5   // x0..x31
`define MEM_OP_W   4   // memory op code toward the memory stage

`endif

//--- src/rv_isa_pkg.sv
`default_nettype none
`include "exe_settings.svh"

package rv_isa_pkg;

    // major opcodes handled by the stage
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3_alu_e;

    typedef enum logic [2:0] {
        F3_BEQ  = 3'b000,
        F3_BNE  = 3'b001,
        F3_BLT  = 3'b100,
        F3_BGE  = 3'b101,
        F3_BLTU = 3'b110,
        F3_BGEU = 3'b111
    } funct3_br_e;

    typedef enum logic [2:0] {
        F3_LB  = 3'b000,
        F3_LH  = 3'b001,
        F3_LW  = 3'b010,
        F3_LBU = 3'b100,
        F3_LHU = 3'b101
    } funct3_ld_e;

    typedef enum logic [2:0] {
        F3_SB = 3'b000,
        F3_SH = 3'b001,
        F3_SW = 3'b010
    } funct3_st_e;

    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;  // sub, sra

    typedef struct packed {
        logic [6:0]             funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        opcode_e                opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]            imm;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        opcode_e                opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]             imm_hi;  // imm[11:5]
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [4:0]             imm_lo;  // imm[4:0]
        opcode_e                opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                   imm_12;
        logic [5:0]             imm_10_5;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [3:0]             imm_4_1;
        logic                   imm_11;
        opcode_e                opcode;
    } b_fmt_t;

    typedef union packed {
        r_fmt_t r_view;
        i_fmt_t i_view;
        s_fmt_t s_view;
        b_fmt_t b_view;
    } inst_u;

endpackage

`default_nettype wire

//--- src/exe_pkg.sv
`default_nettype none
`include "exe_settings.svh"

package exe_pkg;

    // operands and instruction from the decode stage
    typedef struct packed {
        logic [`XLEN-1:0]       op1;
        logic [`XLEN-1:0]       op2;     // holds the immediate for op-imm
        logic [`INST_W-1:0]     inst;
        logic [`XLEN-1:0]       pc;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   rd_we;
    } id_exe_t;

    typedef enum logic [2:0] {
        CLS_ALU, CLS_LUI_AUIPC, CLS_LOAD, CLS_STORE,
        CLS_BRANCH, CLS_JAL, CLS_JALR, CLS_ILLEGAL
    } uop_class_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_op_e;

    typedef enum logic [`MEM_OP_W-1:0] {
        MEM_NOP = 0, LB, LH, LW, LBU, LHU, SB, SH, SW
    } mem_op_e;

    typedef struct packed {
        uop_class_e             cls;
        alu_op_e                alu_op;
        rv_isa_pkg::funct3_br_e br_funct3;
        mem_op_e                mem_op;
        logic [`XLEN-1:0]       op1;
        logic [`XLEN-1:0]       op2;
        logic [`XLEN-1:0]       imm;     // sign extended
        logic [`XLEN-1:0]       pc;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   rd_we;
    } uop_t;

    typedef struct packed {
        logic                   we;
        logic [`REG_ADDR_W-1:0] waddr;
        logic [`XLEN-1:0]       wdata;
    } reg_wr_t;

    typedef struct packed {
        logic             we;
        mem_op_e          op;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] data;
    } mem_req_t;

    typedef struct packed {
        reg_wr_t  reg_wr;
        mem_req_t mem;
    } exe_mem_t;

    typedef struct packed {
        logic             enable;
        logic [`XLEN-1:0] addr;
    } jump_t;

endpackage

`default_nettype wire

//--- src/exe_decode.sv
`timescale 1ns/1ps
`default_nettype none
`include "exe_settings.svh"

module exe_decode (
    input  wire exe_pkg::id_exe_t id_exe_i,
    output exe_pkg::uop_t         uop_o
);

    rv_isa_pkg::inst_u inst;
    logic [`XLEN-1:0]  imm_i;
    logic [`XLEN-1:0]  imm_s;
    logic [`XLEN-1:0]  imm_b;
    logic [`XLEN-1:0]  imm_j;
    logic              f7_ok;
    logic              f7_alt;

    function automatic exe_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt,
                                                 input logic sub_ok);
        case (rv_isa_pkg::funct3_alu_e'(f3))
            rv_isa_pkg::F3_ADD_SUB: alu_sel = (alt && sub_ok) ? exe_pkg::ALU_SUB : exe_pkg::ALU_ADD;
            rv_isa_pkg::F3_SLL:     alu_sel = exe_pkg::ALU_SLL;
            rv_isa_pkg::F3_SLT:     alu_sel = exe_pkg::ALU_SLT;
            rv_isa_pkg::F3_SLTU:    alu_sel = exe_pkg::ALU_SLTU;
            rv_isa_pkg::F3_XOR:     alu_sel = exe_pkg::ALU_XOR;
            rv_isa_pkg::F3_SRL_SRA: alu_sel = alt ? exe_pkg::ALU_SRA : exe_pkg::ALU_SRL;
            rv_isa_pkg::F3_OR:      alu_sel = exe_pkg::ALU_OR;
            default:                alu_sel = exe_pkg::ALU_AND;
        endcase
    endfunction

    assign inst = id_exe_i.inst;

    assign imm_i = {{(`XLEN-12){inst.i_view.imm[11]}}, inst.i_view.imm};
    assign imm_s = {{(`XLEN-12){inst.s_view.imm_hi[6]}}, inst.s_view.imm_hi, inst.s_view.imm_lo};
    assign imm_b = {{(`XLEN-13){inst.b_view.imm_12}}, inst.b_view.imm_12, inst.b_view.imm_11,
                    inst.b_view.imm_10_5, inst.b_view.imm_4_1, 1'b0};
    // J immediate is scattered over the R fields
    assign imm_j = {{(`XLEN-21){inst.r_view.funct7[6]}}, inst.r_view.funct7[6], inst.r_view.rs1,
                    inst.r_view.funct3, inst.r_view.rs2[0], inst.r_view.funct7[5:0],
                    inst.r_view.rs2[4:1], 1'b0};

    assign f7_alt = (inst.r_view.funct7 == rv_isa_pkg::FUNCT7_ALT);
    assign f7_ok  = (inst.r_view.funct7 == rv_isa_pkg::FUNCT7_BASE) || f7_alt;

    always_comb begin
        uop_o           = '0;
        uop_o.cls       = exe_pkg::CLS_ILLEGAL;  // bubble unless matched below
        uop_o.alu_op    = alu_sel(inst.r_view.funct3, f7_alt,
                                  inst.r_view.opcode == rv_isa_pkg::OPC_OP);
        uop_o.br_funct3 = rv_isa_pkg::funct3_br_e'(inst.b_view.funct3);
        uop_o.mem_op    = exe_pkg::MEM_NOP;
        uop_o.op1       = id_exe_i.op1;
        uop_o.op2       = id_exe_i.op2;
        uop_o.pc        = id_exe_i.pc;
        uop_o.rd        = id_exe_i.rd;
        case (inst.r_view.opcode)
            rv_isa_pkg::OPC_OP_IMM: begin
                // funct7 only qualifies the shifts here
                if (f7_ok || (inst.r_view.funct3 != rv_isa_pkg::F3_SLL
                              && inst.r_view.funct3 != rv_isa_pkg::F3_SRL_SRA)) begin
                    uop_o.cls = exe_pkg::CLS_ALU;
                end
            end
            rv_isa_pkg::OPC_OP: if (f7_ok) uop_o.cls = exe_pkg::CLS_ALU;
            rv_isa_pkg::OPC_LUI, rv_isa_pkg::OPC_AUIPC: uop_o.cls = exe_pkg::CLS_LUI_AUIPC;
            rv_isa_pkg::OPC_LOAD: begin
                uop_o.imm = imm_i;
                case (rv_isa_pkg::funct3_ld_e'(inst.i_view.funct3))
                    rv_isa_pkg::F3_LB:  uop_o.mem_op = exe_pkg::LB;
                    rv_isa_pkg::F3_LH:  uop_o.mem_op = exe_pkg::LH;
                    rv_isa_pkg::F3_LW:  uop_o.mem_op = exe_pkg::LW;
                    rv_isa_pkg::F3_LBU: uop_o.mem_op = exe_pkg::LBU;
                    rv_isa_pkg::F3_LHU: uop_o.mem_op = exe_pkg::LHU;
                    default:            uop_o.mem_op = exe_pkg::MEM_NOP;
                endcase
                if (uop_o.mem_op != exe_pkg::MEM_NOP) uop_o.cls = exe_pkg::CLS_LOAD;
            end
            rv_isa_pkg::OPC_STORE: begin
                uop_o.imm = imm_s;
                case (rv_isa_pkg::funct3_st_e'(inst.s_view.funct3))
                    rv_isa_pkg::F3_SB: uop_o.mem_op = exe_pkg::SB;
                    rv_isa_pkg::F3_SH: uop_o.mem_op = exe_pkg::SH;
                    rv_isa_pkg::F3_SW: uop_o.mem_op = exe_pkg::SW;
                    default:           uop_o.mem_op = exe_pkg::MEM_NOP;
                endcase
                if (uop_o.mem_op != exe_pkg::MEM_NOP) uop_o.cls = exe_pkg::CLS_STORE;
            end
            rv_isa_pkg::OPC_BRANCH: begin
                uop_o.imm = imm_b;
                // 010/011 unused
                if (inst.b_view.funct3[2:1] != 2'b01) uop_o.cls = exe_pkg::CLS_BRANCH;
            end
            rv_isa_pkg::OPC_JAL: begin
                uop_o.imm = imm_j;
                uop_o.cls = exe_pkg::CLS_JAL;
            end
            rv_isa_pkg::OPC_JALR: begin
                uop_o.imm = imm_i;
                uop_o.cls = exe_pkg::CLS_JALR;
            end
            default: ;
        endcase
        // only classes that write rd keep the write enable
        case (uop_o.cls)
            exe_pkg::CLS_ALU, exe_pkg::CLS_LUI_AUIPC, exe_pkg::CLS_LOAD,
            exe_pkg::CLS_JAL, exe_pkg::CLS_JALR: uop_o.rd_we = id_exe_i.rd_we;
            default:                             uop_o.rd_we = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- src/exe_compute.sv
`timescale 1ns/1ps
`default_nettype none
`include "exe_settings.svh"

module exe_compute (
    input  wire                  rst_i,
    input  wire exe_pkg::uop_t   uop_i,
    output exe_pkg::exe_mem_t    exe_res_o,
    output exe_pkg::jump_t       jump_o
);

    logic [`XLEN-1:0] alu_res;
    logic [`XLEN-1:0] mem_addr;
    logic [`XLEN-1:0] link;
    logic [`XLEN-1:0] jump_addr;
    logic [4:0]       shamt;
    logic             br_taken;
    logic             jump_en;

    assign shamt    = uop_i.op2[4:0];
    assign mem_addr = uop_i.op1 + uop_i.imm;  // load and store
    assign link     = uop_i.pc + `XLEN'(4);

    always_comb begin
        case (uop_i.alu_op)
            exe_pkg::ALU_ADD:  alu_res = uop_i.op1 + uop_i.op2;
            exe_pkg::ALU_SUB:  alu_res = uop_i.op1 - uop_i.op2;
            exe_pkg::ALU_AND:  alu_res = uop_i.op1 & uop_i.op2;
            exe_pkg::ALU_OR:   alu_res = uop_i.op1 | uop_i.op2;
            exe_pkg::ALU_XOR:  alu_res = uop_i.op1 ^ uop_i.op2;
            exe_pkg::ALU_SLT:  alu_res = `XLEN'($signed(uop_i.op1) < $signed(uop_i.op2));
            exe_pkg::ALU_SLTU: alu_res = `XLEN'(uop_i.op1 < uop_i.op2);
            exe_pkg::ALU_SLL:  alu_res = uop_i.op1 << shamt;
            exe_pkg::ALU_SRL:  alu_res = uop_i.op1 >> shamt;
            exe_pkg::ALU_SRA:  alu_res = $signed(uop_i.op1) >>> shamt;
            default:           alu_res = '0;
        endcase
    end

    always_comb begin
        case (uop_i.br_funct3)
            rv_isa_pkg::F3_BEQ:  br_taken = (uop_i.op1 == uop_i.op2);
            rv_isa_pkg::F3_BNE:  br_taken = (uop_i.op1 != uop_i.op2);
            rv_isa_pkg::F3_BLT:  br_taken = $signed(uop_i.op1) < $signed(uop_i.op2);
            rv_isa_pkg::F3_BGE:  br_taken = $signed(uop_i.op1) >= $signed(uop_i.op2);
            rv_isa_pkg::F3_BLTU: br_taken = uop_i.op1 < uop_i.op2;
            rv_isa_pkg::F3_BGEU: br_taken = uop_i.op1 >= uop_i.op2;
            default:             br_taken = 1'b0;
        endcase
    end

    always_comb begin
        exe_res_o = '0;  // no writes, MEM_NOP
        jump_en   = 1'b0;
        jump_addr = '0;
        case (uop_i.cls)
            exe_pkg::CLS_ALU: begin
                exe_res_o.reg_wr.we    = uop_i.rd_we;
                exe_res_o.reg_wr.waddr = uop_i.rd;
                exe_res_o.reg_wr.wdata = alu_res;
            end
            exe_pkg::CLS_LUI_AUIPC: begin
                // upstream puts the upper immediate and zero or pc in the operands
                exe_res_o.reg_wr.we    = uop_i.rd_we;
                exe_res_o.reg_wr.waddr = uop_i.rd;
                exe_res_o.reg_wr.wdata = uop_i.op1 + uop_i.op2;
            end
            exe_pkg::CLS_LOAD: begin
                exe_res_o.reg_wr.we    = uop_i.rd_we;  // data filled in by mem stage
                exe_res_o.reg_wr.waddr = uop_i.rd;
                exe_res_o.mem.op       = uop_i.mem_op;
                exe_res_o.mem.addr     = mem_addr;
            end
            exe_pkg::CLS_STORE: begin
                exe_res_o.mem.we   = 1'b1;
                exe_res_o.mem.op   = uop_i.mem_op;
                exe_res_o.mem.addr = mem_addr;
                exe_res_o.mem.data = uop_i.op2;
            end
            exe_pkg::CLS_BRANCH: begin
                jump_en   = br_taken;
                jump_addr = uop_i.pc + uop_i.imm;
            end
            exe_pkg::CLS_JAL, exe_pkg::CLS_JALR: begin
                exe_res_o.reg_wr.we    = uop_i.rd_we;
                exe_res_o.reg_wr.waddr = uop_i.rd;
                exe_res_o.reg_wr.wdata = link;
                jump_en                = 1'b1;
                jump_addr              = (uop_i.cls == exe_pkg::CLS_JAL) ? uop_i.pc + uop_i.imm
                                                                         : uop_i.op1 + uop_i.imm;
            end
            default: ;  // illegal acts as bubble
        endcase
    end

    assign jump_o = {jump_en && !rst_i, jump_addr};  // pipeline ctrl must not redirect in reset

    // memory stage only takes a write with a store op
    always_comb begin
        assert final (!exe_res_o.mem.we
                      || exe_res_o.mem.op inside {exe_pkg::SB, exe_pkg::SH, exe_pkg::SW})
            else $error("exe_compute: mem write without a store op");
    end

endmodule

`default_nettype wire

//--- src/exe_mem_reg.sv
`timescale 1ns/1ps
`default_nettype none

module exe_mem_reg (
    input  wire                    clk_i,
    input  wire                    rst_i,
    input  wire exe_pkg::exe_mem_t exe_res_i,
    output exe_pkg::exe_mem_t      exe_mem_o
);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            exe_mem_o.reg_wr.we    <= 1'b0;
            exe_mem_o.reg_wr.waddr <= '0;
            exe_mem_o.reg_wr.wdata <= '0;
            exe_mem_o.mem.we       <= 1'b0;
            exe_mem_o.mem.op       <= exe_pkg::MEM_NOP;
            exe_mem_o.mem.addr     <= '0;
            exe_mem_o.mem.data     <= '0;
        end else begin
            exe_mem_o <= exe_res_i;  // no stall, loads every cycle
        end
    end

    // compute never asks for a reg write and a mem write at once
    assert property (@(posedge clk_i)
        !(exe_res_i.reg_wr.we && exe_res_i.mem.we))
        else $error("exe_mem_reg: reg write and mem write together");

endmodule

`default_nettype wire

//--- src/exe_top.sv
`timescale 1ns/1ps
`default_nettype none

module exe_top (
    input  wire                    clk_i,
    input  wire                    rst_i,
    input  wire exe_pkg::id_exe_t  id_exe_i,
    output exe_pkg::exe_mem_t      exe_mem_o,
    output exe_pkg::jump_t         jump_o
);

    exe_pkg::uop_t     uop;
    exe_pkg::exe_mem_t exe_res;

    exe_decode u_decode (
        .id_exe_i (id_exe_i),
        .uop_o    (uop)
    );

    exe_compute u_compute (
        .rst_i     (rst_i),
        .uop_i     (uop),
        .exe_res_o (exe_res),
        .jump_o    (jump_o)   // straight to pipeline ctrl
    );

    exe_mem_reg u_exe_mem (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .exe_res_i (exe_res),
        .exe_mem_o (exe_mem_o)
    );

endmodule

`default_nettype wire

//--- verif/exe_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "exe_settings.svh"

module exe_tb;

    localparam int MAX_CYCLES = 1500;  // 4 reset + 6 groups of 200, with margin
    localparam int GROUP_LEN  = 200;

    logic              clk;
    logic              rst;
    exe_pkg::id_exe_t  id_exe;
    exe_pkg::exe_mem_t exe_mem;
    exe_pkg::jump_t    jump;
    exe_pkg::exe_mem_t exp_res;
    exe_pkg::exe_mem_t exp_res_q;  // expected register contents
    exe_pkg::jump_t    exp_jump;
    int                mem_errs  = 0;
    int                jump_errs = 0;
    int                rst_errs  = 0;
    int                cycles    = 0;

    exe_top uut (
        .clk_i     (clk),
        .rst_i     (rst),
        .id_exe_i  (id_exe),
        .exe_mem_o (exe_mem),
        .jump_o    (jump)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [`XLEN-1:0] sext12(input logic [11:0] imm);
        return {{(`XLEN-12){imm[11]}}, imm};
    endfunction

    function automatic logic [`XLEN-1:0] alu_ref(input logic [2:0] f3, input logic alt,
                                                 input logic [`XLEN-1:0] a,
                                                 input logic [`XLEN-1:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return `XLEN'($signed(a) < $signed(b));
            3'd3: return `XLEN'(a < b);
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input logic [`XLEN-1:0] a,
                                        input logic [`XLEN-1:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic expect_rd(input logic [`XLEN-1:0] data);
        exp_res.reg_wr.we    = id_exe.rd_we;
        exp_res.reg_wr.waddr = id_exe.rd;
        exp_res.reg_wr.wdata = data;
    endtask

    task automatic drive_alu();
        logic [2:0]  f3;
        logic        is_imm;
        logic        alt;
        logic [6:0]  f7;
        logic [11:0] imm;
        f3     = 3'($urandom);
        is_imm = 1'($urandom);
        alt    = (f3 == 3'd5 || (f3 == 3'd0 && !is_imm)) ? 1'($urandom) : 1'b0;
        f7     = alt ? rv_isa_pkg::FUNCT7_ALT : rv_isa_pkg::FUNCT7_BASE;
        imm    = 12'($urandom);
        if (is_imm) begin
            if (f3 == 3'd1 || f3 == 3'd5) imm[11:5] = f7;  // shift immediates
            id_exe.op2  = sext12(imm);
            id_exe.inst = {imm, 5'($urandom), f3, id_exe.rd, rv_isa_pkg::OPC_OP_IMM};
        end else begin
            id_exe.inst = {f7, 5'($urandom), 5'($urandom), f3, id_exe.rd, rv_isa_pkg::OPC_OP};
        end
        expect_rd(alu_ref(f3, alt, id_exe.op1, id_exe.op2));
    endtask

    task automatic drive_upper();
        logic [19:0] uimm;
        logic        is_lui;
        uimm        = 20'($urandom);
        is_lui      = 1'($urandom);
        id_exe.op1  = is_lui ? '0 : id_exe.pc;
        id_exe.op2  = {uimm, 12'd0};
        id_exe.inst = {uimm, id_exe.rd, is_lui ? rv_isa_pkg::OPC_LUI : rv_isa_pkg::OPC_AUIPC};
        expect_rd(id_exe.op1 + id_exe.op2);
    endtask

    task automatic drive_mem();
        logic [2:0]  f3;
        logic [2:0]  pick;
        logic [11:0] imm;
        imm              = 12'($urandom);
        exp_res.mem.addr = id_exe.op1 + sext12(imm);
        if (1'($urandom)) begin
            f3 = 3'($urandom % 3);
            id_exe.inst = {imm[11:5], 5'($urandom), 5'($urandom), f3, imm[4:0],
                           rv_isa_pkg::OPC_STORE};
            exp_res.mem.we   = 1'b1;
            exp_res.mem.op   = (f3 == 3'd0) ? exe_pkg::SB : (f3 == 3'd1) ? exe_pkg::SH : exe_pkg::SW;
            exp_res.mem.data = id_exe.op2;
        end else begin
            pick = 3'($urandom % 5);
            f3   = (pick > 3'd2) ? pick + 3'd1 : pick;  // skips the unused 011
            id_exe.inst = {imm, 5'($urandom), f3, id_exe.rd, rv_isa_pkg::OPC_LOAD};
            case (f3)
                3'd0: exp_res.mem.op = exe_pkg::LB;
                3'd1: exp_res.mem.op = exe_pkg::LH;
                3'd2: exp_res.mem.op = exe_pkg::LW;
                3'd4: exp_res.mem.op = exe_pkg::LBU;
                default: exp_res.mem.op = exe_pkg::LHU;
            endcase
            expect_rd('0);
        end
    endtask

    task automatic drive_branch();
        logic [2:0]  f3;
        logic [12:0] imm;
        int          pick;
        pick = int'($urandom % 6);
        f3   = (pick < 2) ? 3'(pick) : 3'(pick + 2);
        imm  = {12'($urandom), 1'b0};
        if ($urandom % 4 == 0) id_exe.op2 = id_exe.op1;  // equal operands now and then
        id_exe.inst = {imm[12], imm[10:5], 5'($urandom), 5'($urandom), f3, imm[4:1], imm[11],
                       rv_isa_pkg::OPC_BRANCH};
        exp_jump.enable = branch_ref(f3, id_exe.op1, id_exe.op2);
        exp_jump.addr   = id_exe.pc + {{(`XLEN-13){imm[12]}}, imm};
    endtask

    task automatic drive_jump();
        logic [20:0] jimm;
        logic [11:0] imm;
        jimm = {20'($urandom), 1'b0};
        imm  = 12'($urandom);
        if (1'($urandom)) begin
            id_exe.inst   = {jimm[20], jimm[10:1], jimm[11], jimm[19:12], id_exe.rd,
                             rv_isa_pkg::OPC_JAL};
            exp_jump.addr = id_exe.pc + {{(`XLEN-21){jimm[20]}}, jimm};
        end else begin
            id_exe.inst   = {imm, 5'($urandom), 3'b000, id_exe.rd, rv_isa_pkg::OPC_JALR};
            exp_jump.addr = id_exe.op1 + sext12(imm);
        end
        exp_jump.enable = 1'b1;
        expect_rd(id_exe.pc + `XLEN'(4));
    endtask

    // expected values stay all zero
    task automatic drive_illegal();
        logic [6:0] opc;
        logic [6:0] f7;
        id_exe.inst = $urandom;
        do f7 = 7'($urandom);
        while (f7 == rv_isa_pkg::FUNCT7_BASE || f7 == rv_isa_pkg::FUNCT7_ALT);
        case ($urandom % 3)
            0: begin
                do opc = 7'($urandom);
                while (opc inside {rv_isa_pkg::OPC_OP_IMM, rv_isa_pkg::OPC_OP,
                                   rv_isa_pkg::OPC_LUI, rv_isa_pkg::OPC_AUIPC,
                                   rv_isa_pkg::OPC_LOAD, rv_isa_pkg::OPC_STORE,
                                   rv_isa_pkg::OPC_BRANCH, rv_isa_pkg::OPC_JAL,
                                   rv_isa_pkg::OPC_JALR});
                id_exe.inst[6:0] = opc;
            end
            1: id_exe.inst = {f7, id_exe.inst[24:7], rv_isa_pkg::OPC_OP};
            default: begin
                id_exe.inst = {f7, id_exe.inst[24:15], 3'd5, id_exe.inst[11:7],
                               rv_isa_pkg::OPC_OP_IMM};
                if (1'($urandom)) id_exe.inst[14:12] = 3'd1;  // slli instead of srli/srai
            end
        endcase
    endtask

    task automatic drive_one(input int kind);
        id_exe.op1   = $urandom;
        id_exe.op2   = $urandom;
        id_exe.pc    = $urandom;
        id_exe.rd    = 5'($urandom);
        id_exe.rd_we = ($urandom % 4) != 0;
        exp_res      = '0;
        exp_jump     = '0;
        case (kind)
            0: drive_alu();
            1: drive_upper();
            2: drive_mem();
            3: drive_branch();
            4: drive_jump();
            default: drive_illegal();
        endcase
    endtask

    task automatic print_counts();
        $display("errors: exe_mem_o %0d, jump_o %0d, reset %0d", mem_errs, jump_errs, rst_errs);
    endtask

    always @(posedge clk) exp_res_q <= exp_res;

    check_jump: assert property (@(posedge clk) disable iff (rst) jump == exp_jump)
        else begin
            jump_errs++;
            $display("error t=%0t jump_o exp %h got %h", $time, $sampled(exp_jump), $sampled(jump));
        end

    check_result: assert property (@(posedge clk) disable iff (rst) exe_mem == exp_res_q)
        else begin
            mem_errs++;
            $display("error t=%0t exe_mem_o exp %h got %h", $time, $sampled(exp_res_q),
                     $sampled(exe_mem));
        end

    check_reset_jump: assert property (@(posedge clk) rst |-> !jump.enable)
        else begin
            rst_errs++;
            $display("error t=%0t jump_o.enable exp 0 got 1", $time);
        end

    check_reset_clear: assert property (@(posedge clk)
        rst |=> !exe_mem.reg_wr.we && !exe_mem.mem.we && !jump.enable)
        else begin
            rst_errs++;
            $display("write or jump enable still set on the cycle after a reset edge, t=%0t", $time);
        end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: stimulus did not finish within %0d cycles", MAX_CYCLES);
            print_counts();
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        void'($urandom(56267));
        rst          = 1'b1;
        id_exe       = '0;
        exp_res      = '0;
        exp_jump     = '0;
        id_exe.rd_we = 1'b1;
        // jal and sw in turn, reset must hold off both writes and the jump
        for (int n = 0; n < 4; n++) begin
            id_exe.inst = n[0] ? {7'd0, 5'd2, 5'd3, 3'b010, 5'd0, rv_isa_pkg::OPC_STORE}
                               : {20'd0, 5'd1, rv_isa_pkg::OPC_JAL};
            @(posedge clk);
            #1;
        end
        rst    = 1'b0;
        id_exe = '0;  // opcode 0 is a bubble
        @(posedge clk);
        for (int kind = 0; kind < 6; kind++) begin
            for (int n = 0; n < GROUP_LEN; n++) begin
                #1 drive_one(kind);
                @(posedge clk);
            end
        end
        #1;
        id_exe   = '0;
        exp_res  = '0;
        exp_jump = '0;
        repeat (2) @(posedge clk);
        #1 print_counts();
        if (mem_errs + jump_errs + rst_errs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+include
src/rv_isa_pkg.sv
src/exe_pkg.sv
src/exe_decode.sv
src/exe_compute.sv
src/exe_mem_reg.sv
src/exe_top.sv
verif/exe_tb.sv

//--- Makefile
TOP = exe_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "PASS: all tests"

lint:
	verilator --lint-only -Wall --timing --assert -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir
